//--- sources.f
src/mem_pkg.sv
src/axi_pkg.sv
src/mem_port_slice.sv
src/mem_rr_arbiter.sv
src/axi_lite_master.sv
src/mem_fabric.sv
verif/mem_fabric_props.sv
verif/tb_mem_fabric.sv

//--- run_sim.sh
#!/bin/sh
# builds the mem_fabric testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module tb_mem_fabric -f sources.f -o tb_mem_fabric
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_mem_fabric 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "Testbench passed"; then
	exit 0
fi
exit 1

//--- verif/tb_mem_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_fabric import mem_pkg::*, axi_pkg::*;;

	localparam int          NUM_PORTS      = 2;
	localparam logic [31:0] PRIV_BASE      = 32'h0001_0000;
	localparam logic [31:0] PRIV_STRIDE    = 32'h0001_0000;
	localparam int          TIMEOUT_CYCLES = 5000;
	localparam int          READY_LIMIT    = 200;
	localparam logic [31:0] SEED           = 32'h32e9_c5f5;
	// slave channel index for the ready delay counters
	localparam int          CH_AW          = 0;
	localparam int          CH_W           = 1;
	localparam int          CH_B           = 2;
	localparam int          CH_AR          = 3;
	localparam int          CH_R           = 4;

	logic                 clk = 1'b0;
	logic                 resetn;
	logic [NUM_PORTS-1:0] mem_valid;
	mem_req_t             mem_req [NUM_PORTS];
	logic [NUM_PORTS-1:0] mem_ready;
	mem_rsp_t             mem_rdata [NUM_PORTS];
	logic                 awvalid;
	logic                 awready = 1'b0;
	axi_aw_t              aw;
	logic                 wvalid;
	logic                 wready = 1'b0;
	axi_w_t               w;
	logic                 bvalid = 1'b0;
	logic                 bready;
	logic                 arvalid;
	logic                 arready = 1'b0;
	axi_ar_t              ar;
	logic                 rvalid = 1'b0;
	logic                 rready;
	logic [31:0]          rdata = '0;

	// slave memory, the expected contents and the AXI address log
	logic [31:0] mem [logic [29:0]];
	logic [31:0] exp_mem [logic [29:0]];
	logic [31:0] log_addr [$];
	logic [2:0]  log_prot [$];
	bit          stall;
	int          wait_cnt [5];
	bit          aw_got;
	bit          w_got;
	bit          ar_got;
	logic [31:0] aw_addr;
	logic [31:0] ar_addr;
	axi_w_t      w_q;
	int          cycles = 0;
	int          errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;

	mem_fabric #(
		.NUM_PORTS  (NUM_PORTS),
		.PRIV_BASE  (PRIV_BASE),
		.PRIV_STRIDE(PRIV_STRIDE)
	) i_dut (
		.clk(clk), .resetn(resetn),
		.mem_valid_i(mem_valid), .mem_req_i(mem_req),
		.mem_ready_o(mem_ready), .mem_rdata_o(mem_rdata),
		.awvalid_o(awvalid), .awready_i(awready), .aw_o(aw),
		.wvalid_o(wvalid), .wready_i(wready), .w_o(w),
		.bvalid_i(bvalid), .bready_o(bready),
		.arvalid_o(arvalid), .arready_i(arready), .ar_o(ar),
		.rvalid_i(rvalid), .rready_o(rready), .rdata_i(rdata)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Testbench failed");
			$finish;
		end
	end

	// unwritten words read back a pattern of their own address
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return {addr[15:0], addr[31:16]} ^ 32'h6c3a_95e1;
	endfunction

	function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] data,
		input logic [3:0] strb);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++)
			if (strb[b])
				res[8*b +: 8] = data[8*b +: 8];
		return res;
	endfunction

	function automatic logic [31:0] slave_word(input logic [29:0] idx);
		if (mem.exists(idx))
			return mem[idx];
		return fill_word({idx, 2'b00});
	endfunction

	function automatic logic [31:0] exp_word(input logic [29:0] idx);
		if (exp_mem.exists(idx))
			return exp_mem[idx];
		return fill_word({idx, 2'b00});
	endfunction

	// private window rule: top byte ff maps into the port's own window
	function automatic logic [31:0] xlat(input int port, input logic [31:0] addr);
		if (addr[31:24] == 8'hff)
			return PRIV_BASE + PRIV_STRIDE * 32'(port) + {8'h00, addr[23:0]};
		return addr;
	endfunction

	// random ready delay of 0 to 4 cycles in stall mode
	function automatic bit ready_now(input int ch);
		if (wait_cnt[ch] < 0)
			wait_cnt[ch] = stall ? int'($urandom_range(4, 0)) : 0;
		if (wait_cnt[ch] == 0) begin
			wait_cnt[ch] = -1;
			return 1'b1;
		end
		wait_cnt[ch]--;
		return 1'b0;
	endfunction

	// AXI slave, responses checked before new address beats
	always @(negedge clk) begin
		if (!resetn) begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
			arready <= 1'b0;
			rvalid  <= 1'b0;
			aw_got = 1'b0;
			w_got  = 1'b0;
			ar_got = 1'b0;
			foreach (wait_cnt[i])
				wait_cnt[i] = -1;
		end else begin
			if (bvalid) begin
				// the response beat is only taken with bready high
				if (bready !== 1'b1)
					mismatch("bready_o", 32'h1, 32'(bready));
				bvalid <= 1'b0;
			end else if (aw_got && w_got && ready_now(CH_B)) begin
				mem[aw_addr[31:2]] = merge(slave_word(aw_addr[31:2]), w_q.data, w_q.strb);
				bvalid <= 1'b1;
				aw_got = 1'b0;
				w_got  = 1'b0;
			end
			if (rvalid) begin
				if (rready !== 1'b1)
					mismatch("rready_o", 32'h1, 32'(rready));
				rvalid <= 1'b0;
			end else if (ar_got && ready_now(CH_R)) begin
				rdata  <= slave_word(ar_addr[31:2]);
				rvalid <= 1'b1;
				ar_got = 1'b0;
			end
			if (awready)
				awready <= 1'b0;
			else if (awvalid && !aw_got && ready_now(CH_AW)) begin
				awready <= 1'b1;
				aw_got  = 1'b1;
				aw_addr = aw.addr;
				log_addr.push_back(aw.addr);
				log_prot.push_back(aw.prot);
			end
			if (wready)
				wready <= 1'b0;
			else if (wvalid && !w_got && ready_now(CH_W)) begin
				wready <= 1'b1;
				w_got  = 1'b1;
				w_q    = w;
			end
			if (arready)
				arready <= 1'b0;
			else if (arvalid && !ar_got && ready_now(CH_AR)) begin
				arready <= 1'b1;
				ar_got  = 1'b1;
				ar_addr = ar.addr;
				log_addr.push_back(ar.addr);
				log_prot.push_back(ar.prot);
			end
		end
	end

	task automatic mismatch(input string name, input logic [31:0] exp_v, input logic [31:0] act);
		$display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp_v, act);
		errors++;
	endtask

	task automatic end_test(input string name, input int err_start);
		tests_run++;
		if (errors == err_start) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: FAILED with %0d errors", name, errors - err_start);
		end
	endtask

	// one native access, a write when any strobe bit is set
	task automatic access(input int port, input logic [31:0] addr, input logic [31:0] wdata,
		input logic [3:0] strb, input bit instr, input bit chk_log);
		logic [31:0] phys;
		logic [31:0] exp_data;
		logic [2:0]  exp_prot;
		int          n;
		phys     = xlat(port, addr);
		exp_data = exp_word(phys[31:2]);
		exp_prot = instr ? 3'b100 : 3'b000;
		@(negedge clk);
		mem_req[port]   = {addr, wdata, strb, instr};
		mem_valid[port] = 1'b1;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!mem_ready[port] && n < READY_LIMIT);
		mem_valid[port] = 1'b0;
		if (!mem_ready[port]) begin
			$display("port %0d got no ready for address %h at %0t", port, addr, $time);
			errors++;
			return;
		end
		if (strb != 4'h0)
			exp_mem[phys[31:2]] = merge(exp_data, wdata, strb);
		else if (mem_rdata[port].rdata !== exp_data)
			mismatch($sformatf("mem_rdata_o[%0d]", port), exp_data, mem_rdata[port].rdata);
		if (chk_log && log_addr[$] !== phys)
			mismatch("axi address", phys, log_addr[$]);
		if (chk_log && log_prot[$] !== exp_prot)
			mismatch("axi prot", 32'(exp_prot), 32'(log_prot[$]));
	endtask

	task automatic check_idle();
		if (mem_ready !== '0)
			mismatch("mem_ready_o", '0, 32'(mem_ready));
		if (awvalid !== 1'b0)
			mismatch("awvalid_o", '0, 32'(awvalid));
		if (wvalid !== 1'b0)
			mismatch("wvalid_o", '0, 32'(wvalid));
		if (arvalid !== 1'b0)
			mismatch("arvalid_o", '0, 32'(arvalid));
	endtask

	task automatic test_reset();
		int e0;
		e0 = errors;
		resetn = 1'b0;
		repeat (16) begin
			@(negedge clk);
			check_idle();
		end
		resetn = 1'b1;
		@(negedge clk);
		check_idle();
		end_test("reset", e0);
	endtask

	task automatic test_write_read(input string name);
		int e0;
		e0 = errors;
		for (int k = 0; k < 4; k++)
			access(0, 32'h0000_1000 + 32'(4 * k), $urandom(), 4'hf, 1'b0, 1'b1);
		access(0, 32'h0000_1000, $urandom(), 4'b0001, 1'b0, 1'b1);
		access(0, 32'h0000_1004, $urandom(), 4'b0110, 1'b0, 1'b1);
		access(0, 32'h0000_1008, $urandom(), 4'b1000, 1'b0, 1'b1);
		// partial write over a word never written before
		access(0, 32'h0000_1040, $urandom(), 4'b0101, 1'b0, 1'b1);
		for (int k = 0; k < 4; k++)
			access(0, 32'h0000_1000 + 32'(4 * k), '0, 4'h0, 1'b0, 1'b1);
		access(0, 32'h0000_1040, '0, 4'h0, 1'b0, 1'b1);
		end_test(name, e0);
	endtask

	task automatic test_private();
		int e0;
		e0 = errors;
		for (int p = 0; p < NUM_PORTS; p++) begin
			access(p, 32'hff00_0020, $urandom(), 4'hf, 1'b0, 1'b1);
			access(p, 32'hff00_0124, $urandom(), 4'b0011, 1'b0, 1'b1);
		end
		for (int p = 0; p < NUM_PORTS; p++) begin
			access(p, 32'hff00_0020, '0, 4'h0, 1'b0, 1'b1);
			access(p, 32'hff00_0124, '0, 4'h0, 1'b0, 1'b1);
		end
		access(1, 32'h0000_2000, $urandom(), 4'hf, 1'b0, 1'b1);
		access(1, 32'h0000_2000, '0, 4'h0, 1'b0, 1'b1);
		end_test("private_window", e0);
	endtask

	task automatic test_prot();
		int e0;
		e0 = errors;
		access(0, 32'h0000_1000, '0, 4'h0, 1'b1, 1'b1);
		access(1, 32'hff00_0020, '0, 4'h0, 1'b1, 1'b1);
		access(0, 32'h0000_1004, '0, 4'h0, 1'b0, 1'b1);
		access(1, 32'h0000_2000, '0, 4'h0, 1'b0, 1'b1);
		end_test("prot", e0);
	endtask

	// each port works in its own 4 KiB region, told apart by address bit 12
	task automatic port_burst(input int p);
		logic [31:0] base;
		base = 32'h0000_4000 + 32'h0000_1000 * 32'(p);
		for (int k = 0; k < 4; k++)
			access(p, base + 32'(4 * k), $urandom(), 4'hf, 1'b0, 1'b0);
		for (int k = 0; k < 4; k++)
			access(p, base + 32'(4 * k), '0, 4'h0, 1'b0, 1'b0);
	endtask

	task automatic test_contention(input string name);
		int e0;
		int first;
		int n;
		e0    = errors;
		first = log_addr.size();
		fork
			port_burst(0);
			port_burst(1);
		join
		n = log_addr.size() - first;
		if (n != 16) begin
			$display("%s: expected 16 AXI transfers, saw %0d", name, n);
			errors++;
		end
		for (int i = first + 1; i < log_addr.size(); i++)
			if (log_addr[i][12] == log_addr[i-1][12]) begin
				$display("%s: same port served twice in a row at transfer %0d", name, i - first);
				errors++;
			end
		end_test(name, e0);
	endtask

	initial begin
		void'($urandom(SEED));
		resetn    = 1'b0;
		mem_valid = '0;
		foreach (mem_req[i])
			mem_req[i] = '0;
		stall = 1'b0;
		test_reset();
		test_write_read("write_read");
		test_private();
		test_prot();
		test_contention("contention");
		// same traffic again under random back-pressure
		stall = 1'b1;
		test_write_read("write_read_stall");
		test_contention("contention_stall");
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/mem_fabric_props.sv
`timescale 1ns/1ps
`default_nettype none

module mem_fabric_props import axi_pkg::*; (
	input logic    clk,
	input logic    resetn,
	input logic    awvalid_i,
	input logic    awready_i,
	input axi_aw_t aw_i,
	input logic    wvalid_i,
	input logic    wready_i,
	input axi_w_t  w_i,
	input logic    arvalid_i,
	input logic    arready_i,
	input axi_ar_t ar_i,
	input logic    req_done_i
);

	// valid and payload held until the slave takes them
	a_aw_hold: assert property (@(posedge clk) disable iff (!resetn)
		awvalid_i && !awready_i |=> awvalid_i && $stable(aw_i))
		else $error("awvalid dropped or aw payload changed before awready");

	a_w_hold: assert property (@(posedge clk) disable iff (!resetn)
		wvalid_i && !wready_i |=> wvalid_i && $stable(w_i))
		else $error("wvalid dropped or w payload changed before wready");

	a_ar_hold: assert property (@(posedge clk) disable iff (!resetn)
		arvalid_i && !arready_i |=> arvalid_i && $stable(ar_i))
		else $error("arvalid dropped or ar payload changed before arready");

	// one transaction at a time
	a_no_aw_ar: assert property (@(posedge clk) disable iff (!resetn)
		!(awvalid_i && arvalid_i))
		else $error("awvalid and arvalid high together");

	a_done_pulse: assert property (@(posedge clk) disable iff (!resetn)
		req_done_i |=> !req_done_i)
		else $error("req_done_o high on two cycles in a row");

endmodule

bind axi_lite_master mem_fabric_props i_props (
	.clk       (clk),
	.resetn    (resetn),
	.awvalid_i (awvalid_o),
	.awready_i (awready_i),
	.aw_i      (aw_o),
	.wvalid_i  (wvalid_o),
	.wready_i  (wready_i),
	.w_i       (w_o),
	.arvalid_i (arvalid_o),
	.arready_i (arready_i),
	.ar_i      (ar_o),
	.req_done_i(req_done_o)
);

`default_nettype wire

//--- src/mem_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module mem_fabric import mem_pkg::*, axi_pkg::*; #(
	parameter int                NUM_PORTS   = 2,
	parameter logic [ADDR_W-1:0] PRIV_BASE   = 32'h0001_0000,
	parameter logic [ADDR_W-1:0] PRIV_STRIDE = 32'h0001_0000
) (
	input  logic                  clk,
	input  logic                  resetn,

	// native ports, one per core
	input  logic [NUM_PORTS-1:0]  mem_valid_i,
	input  mem_req_t              mem_req_i   [NUM_PORTS],
	output logic [NUM_PORTS-1:0]  mem_ready_o,
	output mem_rsp_t              mem_rdata_o [NUM_PORTS],

	// AXI4-Lite master
	output logic                  awvalid_o,
	input  logic                  awready_i,
	output axi_aw_t               aw_o,
	output logic                  wvalid_o,
	input  logic                  wready_i,
	output axi_w_t                w_o,
	input  logic                  bvalid_i,
	output logic                  bready_o,
	output logic                  arvalid_o,
	input  logic                  arready_i,
	output axi_ar_t               ar_o,
	input  logic                  rvalid_i,
	output logic                  rready_o,
	input  logic [AXI_DATA_W-1:0] rdata_i
);

	logic [NUM_PORTS-1:0] slice_full;
	logic [NUM_PORTS-1:0] slice_done;
	mem_req_t             slice_req [NUM_PORTS];
	mem_rsp_t             arb_rsp;
	logic                 arb_valid;
	mem_req_t             arb_req;
	logic                 mst_done;
	mem_rsp_t             mst_rsp;

	// each port gets its own private window
	for (genvar i = 0; i < NUM_PORTS; i++) begin : g_slice
		mem_port_slice #(
			.PRIV_START(PRIV_BASE + PRIV_STRIDE * ADDR_W'(i))
		) i_slice (
			.clk        (clk),
			.resetn     (resetn),
			.mem_valid_i(mem_valid_i[i]),
			.mem_req_i  (mem_req_i[i]),
			.mem_ready_o(mem_ready_o[i]),
			.mem_rdata_o(mem_rdata_o[i]),
			.full_o     (slice_full[i]),
			.req_o      (slice_req[i]),
			.done_i     (slice_done[i]),
			.rsp_i      (arb_rsp)
		);
	end

	mem_rr_arbiter #(
		.NUM_PORTS(NUM_PORTS)
	) i_arbiter (
		.clk        (clk),
		.resetn     (resetn),
		.full_i     (slice_full),
		.req_i      (slice_req),
		.done_o     (slice_done),
		.rsp_o      (arb_rsp),
		.req_valid_o(arb_valid),
		.req_o      (arb_req),
		.req_done_i (mst_done),
		.rsp_i      (mst_rsp)
	);

	axi_lite_master i_master (
		.clk        (clk),
		.resetn     (resetn),
		.req_valid_i(arb_valid),
		.req_i      (arb_req),
		.req_done_o (mst_done),
		.rsp_o      (mst_rsp),
		.awvalid_o  (awvalid_o),
		.awready_i  (awready_i),
		.aw_o       (aw_o),
		.wvalid_o   (wvalid_o),
		.wready_i   (wready_i),
		.w_o        (w_o),
		.bvalid_i   (bvalid_i),
		.bready_o   (bready_o),
		.arvalid_o  (arvalid_o),
		.arready_i  (arready_i),
		.ar_o       (ar_o),
		.rvalid_i   (rvalid_i),
		.rready_o   (rready_o),
		.rdata_i    (rdata_i)
	);

endmodule

`default_nettype wire

//--- src/axi_lite_master.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_master import mem_pkg::*, axi_pkg::*; (
	input  logic                  clk,
	input  logic                  resetn,

	// native request from the arbiter
	input  logic                  req_valid_i,
	input  mem_req_t              req_i,
	output logic                  req_done_o,
	output mem_rsp_t              rsp_o,

	// write channels
	output logic                  awvalid_o,
	input  logic                  awready_i,
	output axi_aw_t               aw_o,
	output logic                  wvalid_o,
	input  logic                  wready_i,
	output axi_w_t                w_o,
	input  logic                  bvalid_i,
	output logic                  bready_o,

	// read channels
	output logic                  arvalid_o,
	input  logic                  arready_i,
	output axi_ar_t               ar_o,
	input  logic                  rvalid_i,
	output logic                  rready_o,
	input  logic [AXI_DATA_W-1:0] rdata_i
);

	localparam logic [1:0] S_IDLE  = 2'd0;
	localparam logic [1:0] S_WRITE = 2'd1;
	localparam logic [1:0] S_READ  = 2'd2;
	localparam logic [1:0] S_DONE  = 2'd3;

	logic [1:0]        state_q;
	logic [DATA_W-1:0] rdata_q;
	logic [2:0]        prot;
	logic              start;

	assign prot  = req_i.instr ? PROT_INSTR : PROT_DATA;
	assign start = (state_q == S_IDLE) && req_valid_i;

	// responses are always accepted
	assign bready_o = 1'b1;
	assign rready_o = 1'b1;

	// one cycle in S_DONE per transaction
	assign req_done_o  = (state_q == S_DONE);
	assign rsp_o.rdata = rdata_q;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state_q   <= S_IDLE;
			awvalid_o <= 1'b0;
			wvalid_o  <= 1'b0;
			arvalid_o <= 1'b0;
		end else begin
			case (state_q)
				S_IDLE: begin
					if (req_valid_i) begin
						if (|req_i.wstrb) begin
							awvalid_o <= 1'b1;
							wvalid_o  <= 1'b1;
							state_q   <= S_WRITE;
						end else begin
							arvalid_o <= 1'b1;
							state_q   <= S_READ;
						end
					end
				end
				S_WRITE: begin
					// aw and w may complete in either order
					if (awready_i)
						awvalid_o <= 1'b0;
					if (wready_i)
						wvalid_o <= 1'b0;
					if (bvalid_i)
						state_q <= S_DONE;
				end
				S_READ: begin
					if (arready_i)
						arvalid_o <= 1'b0;
					if (rvalid_i)
						state_q <= S_DONE;
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// channel payloads latched at start, read data on the R beat
	always_ff @(posedge clk) begin
		if (start) begin
			aw_o <= '{addr: req_i.addr.phys, prot: prot};
			w_o  <= '{data: req_i.wdata, strb: req_i.wstrb};
			ar_o <= '{addr: req_i.addr.phys, prot: prot};
		end
		if ((state_q == S_READ) && rvalid_i)
			rdata_q <= rdata_i;
	end

endmodule

`default_nettype wire

//--- src/mem_rr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_rr_arbiter import mem_pkg::*; #(
	parameter int NUM_PORTS = 2
) (
	input  logic                 clk,
	input  logic                 resetn,

	// slice side
	input  logic [NUM_PORTS-1:0] full_i,
	input  mem_req_t             req_i [NUM_PORTS],
	output logic [NUM_PORTS-1:0] done_o,
	output mem_rsp_t             rsp_o,

	// master side
	output logic                 req_valid_o,
	output mem_req_t             req_o,
	input  logic                 req_done_i,
	input  mem_rsp_t             rsp_i
);

	localparam int IDX_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

	logic [IDX_W-1:0] last_q;
	logic [IDX_W-1:0] grant_q;
	logic [IDX_W-1:0] next_idx;
	logic             found;

	// first full port after the last served one, wrapping around
	always_comb begin
		int cand;
		next_idx = last_q;
		found    = 1'b0;
		for (int k = 1; k <= NUM_PORTS; k++) begin
			cand = (int'(last_q) + k) % NUM_PORTS;
			if (!found && full_i[cand]) begin
				found    = 1'b1;
				next_idx = IDX_W'(cand);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			req_valid_o <= 1'b0;
			grant_q     <= '0;
			// port 0 goes first after reset
			last_q      <= IDX_W'(NUM_PORTS - 1);
		end else if (req_valid_o) begin
			if (req_done_i) begin
				req_valid_o <= 1'b0;
				last_q      <= grant_q;
			end
		end else if (found) begin
			req_valid_o <= 1'b1;
			grant_q     <= next_idx;
		end
	end

	// selected request stays put until req_done_i
	always_ff @(posedge clk) begin
		if (!req_valid_o && found)
			req_o <= req_i[next_idx];
	end

	// done goes only to the granted port
	always_comb begin
		done_o          = '0;
		done_o[grant_q] = req_valid_o && req_done_i;
	end

	assign rsp_o = rsp_i;

endmodule

`default_nettype wire

//--- src/mem_port_slice.sv
`timescale 1ns/1ps
`default_nettype none

module mem_port_slice import mem_pkg::*; #(
	parameter logic [ADDR_W-1:0] PRIV_START = 32'h0001_0000
) (
	input  logic     clk,
	input  logic     resetn,

	// core side
	input  logic     mem_valid_i,
	input  mem_req_t mem_req_i,
	output logic     mem_ready_o,
	output mem_rsp_t mem_rdata_o,

	// arbiter side
	output logic     full_o,
	output mem_req_t req_o,
	input  logic     done_i,
	input  mem_rsp_t rsp_i
);

	logic     full_q;
	logic     capture;
	mem_req_t req_xlat;

	// ready_o high means the core still holds the old request
	assign capture = mem_valid_i && !full_q && !mem_ready_o;
	assign full_o  = full_q;

	// private window remap, the same word decoded as tag plus offset
	always_comb begin
		req_xlat = mem_req_i;
		if (mem_req_i.addr.priv.tag == PRIV_TAG)
			req_xlat.addr.phys = PRIV_START + ADDR_W'(mem_req_i.addr.priv.offset);
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			full_q      <= 1'b0;
			mem_ready_o <= 1'b0;
		end else begin
			// ready follows done by one cycle
			mem_ready_o <= done_i;
			if (done_i)
				full_q <= 1'b0;
			else if (capture)
				full_q <= 1'b1;
		end
	end

	// request and read data slots
	always_ff @(posedge clk) begin
		if (capture)
			req_o <= req_xlat;
		if (done_i)
			mem_rdata_o <= rsp_i;
	end

endmodule

`default_nettype wire

//--- src/axi_pkg.sv
`default_nettype none

package axi_pkg;

	localparam int AXI_ADDR_W = 32;
	localparam int AXI_DATA_W = 32;
	localparam int AXI_STRB_W = 4;

	// arprot / awprot encodings
	localparam logic [2:0] PROT_DATA  = 3'b000;
	// instruction access, bit 2 set
	localparam logic [2:0] PROT_INSTR = 3'b100;

	// write address channel payload
	typedef struct packed {
		logic [AXI_ADDR_W-1:0] addr;
		logic [2:0]            prot;
	} axi_aw_t;

	// write data channel payload
	typedef struct packed {
		logic [AXI_DATA_W-1:0] data;
		logic [AXI_STRB_W-1:0] strb;
	} axi_w_t;

	// read address channel payload
	typedef struct packed {
		logic [AXI_ADDR_W-1:0] addr;
		logic [2:0]            prot;
	} axi_ar_t;

endpackage

`default_nettype wire

//--- src/mem_pkg.sv
`default_nettype none

package mem_pkg;

	// native bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = 4;

	// top address byte of a private-window access
	localparam logic [7:0] PRIV_TAG = 8'hff;

	// private view of an address word
	typedef struct packed {
		logic [7:0]  tag;
		logic [23:0] offset;
	} mem_priv_addr_t;

	// one address word, read raw or as tag plus offset
	typedef union packed {
		logic [ADDR_W-1:0] phys;
		mem_priv_addr_t    priv;
	} mem_addr_u;

	// request as held by a core until ready
	typedef struct packed {
		mem_addr_u         addr;
		logic [DATA_W-1:0] wdata;
		// any strobe bit set means a write
		logic [STRB_W-1:0] wstrb;
		logic              instr;
	} mem_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] rdata;
	} mem_rsp_t;

endpackage

`default_nettype wire
